//--- Makefile
TOP = tb_trigger_chain_array

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir -o sim_exe
	./obj_dir/sim_exe 2>&1 | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/trig_pkg.sv
package trig_pkg;

    // channel and sample geometry
    localparam int NUM_CHAN         = 8;
    localparam int CHAN_BITS        = $clog2(NUM_CHAN);
    localparam int SAMPLES_PER_WORD = 8;
    localparam int IN_BITS          = 12;
    localparam int OUT_BITS         = 5;

    // wishbone widths
    localparam int WB_ADR_BITS = 22;
    localparam int WB_DAT_BITS = 32;

    // gain is unsigned fixed point, 4 fraction bits, so 16 is unity
    localparam int GAIN_BITS      = 8;
    localparam int GAIN_FRAC_BITS = 4;
    localparam logic [GAIN_BITS-1:0] GAIN_RESET = GAIN_BITS'(1 << GAIN_FRAC_BITS);

    // drop the gain fraction, then requantize 12 bits down to 5
    localparam int OUT_SHIFT = GAIN_FRAC_BITS + (IN_BITS - OUT_BITS);

    // signed diff (13b) times zero-extended gain (9b)
    localparam int PROD_BITS = (IN_BITS + 1) + (GAIN_BITS + 1);

    // output clamp range, -16 to 15
    localparam int SAT_MAX = (1 << (OUT_BITS - 1)) - 1;
    localparam int SAT_MIN = -(1 << (OUT_BITS - 1));

    localparam int CNT_BITS      = 16;
    // wide enough to hold 0..8 clipped lanes
    localparam int CLIP_SUM_BITS = $clog2(SAMPLES_PER_WORD + 1);

    // address map: channel in 12:10, register word in 7:2
    localparam int CHAN_LSB = 10;
    localparam int REG_LSB  = 2;
    localparam int REG_BITS = 6;
    // bits 21:13, 9:8 and 1:0 must be zero
    localparam logic [WB_ADR_BITS-1:0] ADR_ERR_MASK = 22'h3FE303;

    typedef logic signed [IN_BITS-1:0]  in_samp_t;
    typedef logic signed [OUT_BITS-1:0] out_samp_t;

    // lane 0 sits in the low bits
    typedef struct packed {
        in_samp_t [SAMPLES_PER_WORD-1:0] lane;
    } in_word_t;

    typedef struct packed {
        out_samp_t [SAMPLES_PER_WORD-1:0] lane;
    } out_word_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WB_ADR_BITS-1:0] adr;
        logic [WB_DAT_BITS-1:0] dat;
        logic [3:0]             sel;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic                   err;
        logic [WB_DAT_BITS-1:0] dat;
    } wb_rsp_t;

    // encodings match the word offset for the mapped registers
    typedef enum logic [1:0] {
        REG_GAIN    = 2'd0,
        REG_OFFSET  = 2'd1,
        REG_CLIPCNT = 2'd2,
        REG_NONE    = 2'd3
    } reg_sel_e;

    typedef struct packed {
        logic                   wr;
        logic                   rd;
        reg_sel_e               reg_sel;
        logic [WB_DAT_BITS-1:0] dat;
    } chan_req_t;

endpackage

//--- design/trigger_chain.sv
`timescale 1ns/1ps

module trigger_chain
    import trig_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst_n_i,
    input  logic                   agc_reset_i,
    input  chan_req_t              req_i,
    output logic [WB_DAT_BITS-1:0] rd_dat_o,
    input  in_word_t               dat_i,
    output out_word_t              dat_o
);

    typedef logic signed [PROD_BITS-1:0] prod_t;

    logic [GAIN_BITS-1:0]         gain_q;
    in_samp_t                     offset_q;
    logic [CNT_BITS-1:0]          cnt_q;
    logic [CNT_BITS:0]            cnt_sum;
    prod_t [SAMPLES_PER_WORD-1:0] prod_d;
    prod_t [SAMPLES_PER_WORD-1:0] prod_q;
    out_word_t                    sat_d;
    logic [CLIP_SUM_BITS-1:0]     clip_sum;
    logic                         cnt_clr;
    logic                         gain_wr;

    assign gain_wr = req_i.wr && (req_i.reg_sel == REG_GAIN);

    // gain and offset registers
    // a write lands at edge N and shapes samples taken from N+1
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            gain_q   <= GAIN_RESET;
            offset_q <= '0;
        end else begin
            if (gain_wr) begin
                gain_q <= req_i.dat[GAIN_BITS-1:0];
            end
            if (req_i.wr && (req_i.reg_sel == REG_OFFSET)) begin
                offset_q <= req_i.dat[IN_BITS-1:0];
            end
        end
    end

    // stage 1: (sample - offset) * gain, full precision
    always_comb begin
        prod_t diff;
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            diff      = prod_t'(dat_i.lane[i]) - prod_t'(offset_q);
            // gain is unsigned, so pad a zero before the signed multiply
            prod_d[i] = diff * prod_t'({1'b0, gain_q});
        end
    end

    // stage 2: shift down to 5 bits and clamp, counting clipped lanes
    always_comb begin
        prod_t shifted;
        clip_sum = '0;
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            shifted = prod_q[i] >>> OUT_SHIFT;
            if (shifted > prod_t'(SAT_MAX)) begin
                sat_d.lane[i] = out_samp_t'(SAT_MAX);
                clip_sum      = clip_sum + 1'b1;
            end else if (shifted < prod_t'(SAT_MIN)) begin
                sat_d.lane[i] = out_samp_t'(SAT_MIN);
                clip_sum      = clip_sum + 1'b1;
            end else begin
                sat_d.lane[i] = shifted[OUT_BITS-1:0];
            end
        end
    end

    // two pipeline registers, output zero out of reset
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            prod_q <= '0;
            dat_o  <= '0;
        end else begin
            prod_q <= prod_d;
            dat_o  <= sat_d;
        end
    end

    // clip counter, saturating
    // clear on agc_reset_i or any write to the count register, clear wins
    assign cnt_clr = agc_reset_i || (req_i.wr && (req_i.reg_sel == REG_CLIPCNT));
    assign cnt_sum = {1'b0, cnt_q} + (CNT_BITS + 1)'(clip_sum);

    always_ff @(posedge aclk) begin
        if (!rst_n_i || cnt_clr) begin
            cnt_q <= '0;
        end else if (cnt_sum[CNT_BITS]) begin
            cnt_q <= '1;
        end else begin
            cnt_q <= cnt_sum[CNT_BITS-1:0];
        end
    end

    // readback mux, offset is the only signed register
    always_comb begin
        case (req_i.reg_sel)
            REG_GAIN:    rd_dat_o = WB_DAT_BITS'(gain_q);
            REG_OFFSET:  rd_dat_o = {{(WB_DAT_BITS - IN_BITS){offset_q[IN_BITS-1]}}, offset_q};
            REG_CLIPCNT: rd_dat_o = WB_DAT_BITS'(cnt_q);
            default:     rd_dat_o = '0;
        endcase
    end

    // count only moves down through a clear
    a_cnt_monotonic: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        !cnt_clr |=> (cnt_q >= $past(cnt_q))
    );

    // gain holds unless the bus writes it
    a_gain_stable: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        !gain_wr |=> $stable(gain_q)
    );

endmodule

//--- design/trigger_chain_array.sv
`timescale 1ns/1ps

module trigger_chain_array
    import trig_pkg::*;
(
    input  logic                      aclk,
    input  logic                      rst_n_i,
    input  logic                      agc_reset_i,
    input  wb_req_t                   wb_req_i,
    output wb_rsp_t                   wb_rsp_o,
    input  in_word_t  [NUM_CHAN-1:0]  dat_i,
    output out_word_t [NUM_CHAN-1:0]  dat_o
);

    // decoder to chains
    chan_req_t [NUM_CHAN-1:0]             chan_req;
    logic                                 bad_adr;
    logic [CHAN_BITS-1:0]                 chan;

    // chains to readback
    logic [NUM_CHAN-1:0][WB_DAT_BITS-1:0] rd_dat;

    // response currently on the bus blocks the held request
    wire rsp_busy  = wb_rsp_o.ack | wb_rsp_o.err;
    wire req_valid = wb_req_i.cyc & wb_req_i.stb;

    wb_chan_decode u_decode (
        .aclk       (aclk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req_i),
        .rsp_busy_i (rsp_busy),
        .chan_req_o (chan_req),
        .bad_adr_o  (bad_adr),
        .chan_o     (chan)
    );

    // one chain per channel, all on aclk
    for (genvar idx = 0; idx < NUM_CHAN; idx++) begin : g_chain
        trigger_chain u_chain (
            .aclk        (aclk),
            .rst_n_i     (rst_n_i),
            .agc_reset_i (agc_reset_i),
            .req_i       (chan_req[idx]),
            .rd_dat_o    (rd_dat[idx]),
            .dat_i       (dat_i[idx]),
            .dat_o       (dat_o[idx])
        );
    end

    wb_readback u_readback (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .chan_i      (chan),
        .bad_adr_i   (bad_adr),
        .req_valid_i (req_valid),
        .rd_dat_i    (rd_dat),
        .wb_rsp_o    (wb_rsp_o)
    );

endmodule

//--- design/wb_chan_decode.sv
`timescale 1ns/1ps

module wb_chan_decode
    import trig_pkg::*;
(
    input  logic                          aclk,
    input  logic                          rst_n_i,
    input  wb_req_t                       wb_req_i,
    input  logic                          rsp_busy_i,
    output chan_req_t [NUM_CHAN-1:0]      chan_req_o,
    output logic                          bad_adr_o,
    output logic [CHAN_BITS-1:0]          chan_o
);

    logic [REG_BITS-1:0] reg_idx;
    reg_sel_e            reg_sel;
    logic                req_go;
    logic [NUM_CHAN-1:0] access;

    // any bit outside the channel and register fields is an error
    assign bad_adr_o = |(wb_req_i.adr & ADR_ERR_MASK);
    assign chan_o    = wb_req_i.adr[CHAN_LSB +: CHAN_BITS];
    assign reg_idx   = wb_req_i.adr[REG_LSB +: REG_BITS];

    // only a fresh, well formed request reaches a channel
    // while ack/err is showing the master still holds the old request
    assign req_go = wb_req_i.cyc && wb_req_i.stb && !rsp_busy_i && !bad_adr_o;

    // register word to select, everything past 0x08 reads as none
    always_comb begin
        case (reg_idx)
            REG_BITS'(0): reg_sel = REG_GAIN;
            REG_BITS'(1): reg_sel = REG_OFFSET;
            REG_BITS'(2): reg_sel = REG_CLIPCNT;
            default:      reg_sel = REG_NONE;
        endcase
    end

    // fan the request out, strobes only for the addressed channel
    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            chan_req_o[i].wr      = req_go && wb_req_i.we && (chan_o == CHAN_BITS'(i));
            chan_req_o[i].rd      = req_go && !wb_req_i.we && (chan_o == CHAN_BITS'(i));
            chan_req_o[i].reg_sel = reg_sel;
            chan_req_o[i].dat     = wb_req_i.dat;
        end
    end

    // per channel access strobe, used by the check below
    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            access[i] = chan_req_o[i].wr | chan_req_o[i].rd;
        end
    end

    // one channel at most is touched per cycle
    a_one_chan: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        $onehot0(access)
    );

endmodule

//--- design/wb_readback.sv
`timescale 1ns/1ps

module wb_readback
    import trig_pkg::*;
(
    input  logic                                  aclk,
    input  logic                                  rst_n_i,
    input  logic [CHAN_BITS-1:0]                  chan_i,
    input  logic                                  bad_adr_i,
    input  logic                                  req_valid_i,
    input  logic [NUM_CHAN-1:0][WB_DAT_BITS-1:0]  rd_dat_i,
    output wb_rsp_t                               wb_rsp_o
);

    logic rsp_busy;
    logic rsp_go;

    // the pulse on the bus now means the held request is done
    assign rsp_busy = wb_rsp_o.ack | wb_rsp_o.err;
    assign rsp_go   = req_valid_i && !rsp_busy;

    // one cycle response, registered at the same edge as the write
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            wb_rsp_o <= '0;
        end else begin
            wb_rsp_o.ack <= rsp_go && !bad_adr_i;
            wb_rsp_o.err <= rsp_go && bad_adr_i;
            // data only rides with ack, zero otherwise
            if (rsp_go && !bad_adr_i) begin
                wb_rsp_o.dat <= rd_dat_i[chan_i];
            end else begin
                wb_rsp_o.dat <= '0;
            end
        end
    end

    // ack and err are mutually exclusive
    a_ack_err_excl: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        !(wb_rsp_o.ack && wb_rsp_o.err)
    );

    // each response is a single cycle pulse
    a_single_pulse: assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        rsp_busy |=> !(wb_rsp_o.ack || wb_rsp_o.err)
    );

endmodule

//--- sim.f
design/trig_pkg.sv
design/wb_chan_decode.sv
design/trigger_chain.sv
design/wb_readback.sv
design/trigger_chain_array.sv
verification/tb_clock_gen.sv
verification/tb_trigger_chain_array.sv

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 40 ns period, 20 ns per phase
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

    // reset held over 5 rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- verification/tb_trigger_chain_array.sv
`timescale 1ns/1ps

module tb_trigger_chain_array
    import trig_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 16;
    localparam int unsigned SEED           = 32'h5745532e;

    typedef enum int {OP_WRITE, OP_READ, OP_BAD, OP_BURST, OP_CLEAR} op_kind_e;

    // one table row, data is the burst length for OP_BURST
    typedef struct packed {
        op_kind_e               kind;
        int                     chan;
        logic [WB_ADR_BITS-1:0] offs;
        logic [WB_DAT_BITS-1:0] data;
        logic [WB_DAT_BITS-1:0] exp;
        bit                     use_model;
    } step_t;

    logic                      aclk;
    logic                      rst_n;
    logic                      agc_reset;
    wb_req_t                   wb_req;
    wb_rsp_t                   wb_rsp;
    in_word_t  [NUM_CHAN-1:0]  dat_in;
    out_word_t [NUM_CHAN-1:0]  dat_out;

    // reference model registers per channel
    int    gain_m   [NUM_CHAN];
    int    offset_m [NUM_CHAN];
    int    cnt_m    [NUM_CHAN];
    step_t steps    [$];

    tb_clock_gen u_clk (
        .clk_o   (aclk),
        .rst_n_o (rst_n)
    );

    trigger_chain_array dut (
        .aclk        (aclk),
        .rst_n_i     (rst_n),
        .agc_reset_i (agc_reset),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .dat_i       (dat_in),
        .dat_o       (dat_out)
    );

    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "response check failed");
        end
    endtask

    task automatic check_word(input string name, input out_word_t exp, input out_word_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "sample check failed");
        end
    endtask

    function automatic void add_step(op_kind_e kind, int chan, int offs, int data, int exp,
                                     bit use_model);
        step_t s;
        s.kind      = kind;
        s.chan      = chan;
        s.offs      = WB_ADR_BITS'(offs);
        s.data      = WB_DAT_BITS'(data);
        s.exp       = WB_DAT_BITS'(exp);
        s.use_model = use_model;
        steps.push_back(s);
    endfunction

    // register view as a bus read sees it
    function automatic logic [WB_DAT_BITS-1:0] model_read(int chan, logic [WB_ADR_BITS-1:0] offs);
        case (offs)
            22'h000: return WB_DAT_BITS'(gain_m[chan]);
            // offset kept as a signed int, so the word is already sign-extended
            22'h004: return WB_DAT_BITS'(offset_m[chan]);
            22'h008: return WB_DAT_BITS'(cnt_m[chan]);
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(int chan, logic [WB_ADR_BITS-1:0] offs,
                                        logic [WB_DAT_BITS-1:0] data);
        case (offs)
            22'h000: gain_m[chan] = int'(data[GAIN_BITS-1:0]);
            22'h004: offset_m[chan] = int'(signed'(data[IN_BITS-1:0]));
            22'h008: cnt_m[chan] = 0;
            default: ;
        endcase
    endfunction

    // offset, gain, shift and clamp of one lane
    function automatic int model_lane(input int sample, input int offs, input int gain,
                                      output bit clipped);
        int lim;
        int val;
        lim     = 1 << (OUT_BITS - 1);
        val     = ((sample - offs) * gain) >>> OUT_SHIFT;
        clipped = (val > lim - 1) || (val < -lim);
        if (val > lim - 1) begin
            val = lim - 1;
        end else if (val < -lim) begin
            val = -lim;
        end
        return val;
    endfunction

    // samples equal to the offset give zero out, so no clips between bursts
    function automatic void drive_idle();
        for (int c = 0; c < NUM_CHAN; c++) begin
            for (int l = 0; l < SAMPLES_PER_WORD; l++) begin
                dat_in[c].lane[l] = in_samp_t'(offset_m[c]);
            end
        end
    endfunction

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout at %0t: reset was never released", $time);
                $display("*** FAILED ***");
                $fatal(1, "reset timeout");
            end
        end
    endtask

    // one full Wishbone cycle, held until ack or err
    task automatic bus_access(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                              input logic [WB_DAT_BITS-1:0] data, output wb_rsp_t rsp);
        int cycles;
        @(negedge aclk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = data;
        wb_req.sel = 4'hF;
        cycles     = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout at %0t: no ack or err for address %h", $time, adr);
                $display("*** FAILED ***");
                $fatal(1, "bus timeout");
            end
        end while (!(wb_rsp.ack || wb_rsp.err));
        rsp        = wb_rsp;
        // stb drops for at least the next edge
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    // random samples on every channel, each checked two falling edges later
    task automatic run_burst(input int len);
        out_word_t [NUM_CHAN-1:0] pend [$];
        out_word_t [NUM_CHAN-1:0] exp_w;
        int                       smp;
        int                       val;
        bit                       clipped;
        for (int k = 0; k < len + 2; k++) begin
            @(negedge aclk);
            // the first two edges still carry idle output
            if (k >= 2) begin
                exp_w = pend.pop_front();
            end else begin
                exp_w = '0;
            end
            for (int c = 0; c < NUM_CHAN; c++) begin
                check_word($sformatf("dat_o[%0d]", c), exp_w[c], dat_out[c]);
            end
            if (k < len) begin
                for (int c = 0; c < NUM_CHAN; c++) begin
                    for (int l = 0; l < SAMPLES_PER_WORD; l++) begin
                        smp = int'($urandom_range((1 << IN_BITS) - 1, 0)) - (1 << (IN_BITS - 1));
                        val = model_lane(smp, offset_m[c], gain_m[c], clipped);
                        // saturating clip count
                        if (clipped && cnt_m[c] < (1 << CNT_BITS) - 1) begin
                            cnt_m[c]++;
                        end
                        dat_in[c].lane[l] = in_samp_t'(smp);
                        exp_w[c].lane[l]  = out_samp_t'(val);
                    end
                end
                pend.push_back(exp_w);
            end else begin
                drive_idle();
            end
        end
    endtask

    task automatic apply_step(input step_t s);
        wb_rsp_t                rsp;
        wb_rsp_t                exp;
        logic [WB_ADR_BITS-1:0] adr;
        adr = WB_ADR_BITS'(s.chan << CHAN_LSB) | s.offs;
        case (s.kind)
            OP_WRITE: begin
                // write ack carries the register as it was at that edge
                exp = '{ack: 1'b1, err: 1'b0, dat: model_read(s.chan, s.offs)};
                bus_access(1'b1, adr, s.data, rsp);
                check_rsp("wb_rsp_o", exp, rsp);
                model_write(s.chan, s.offs, s.data);
                drive_idle();
            end
            OP_READ: begin
                exp = '{ack: 1'b1, err: 1'b0, dat: s.exp};
                if (s.use_model) begin
                    exp.dat = model_read(s.chan, s.offs);
                end
                bus_access(1'b0, adr, '0, rsp);
                check_rsp("wb_rsp_o", exp, rsp);
            end
            OP_BAD: begin
                exp = '{ack: 1'b0, err: 1'b1, dat: '0};
                bus_access(1'b1, adr, s.data, rsp);
                check_rsp("wb_rsp_o", exp, rsp);
            end
            OP_BURST: begin
                run_burst(int'(s.data));
            end
            default: begin
                // agc reset pulse over one edge clears every counter
                @(negedge aclk);
                agc_reset = 1'b1;
                @(negedge aclk);
                agc_reset = 1'b0;
                for (int c = 0; c < NUM_CHAN; c++) begin
                    cnt_m[c] = 0;
                end
            end
        endcase
    endtask

    function automatic void build_table();
        // reset values on every channel
        for (int c = 0; c < NUM_CHAN; c++) begin
            add_step(OP_READ, c, 'h00, 0, 16, 1'b0);
            add_step(OP_READ, c, 'h04, 0, 0, 1'b0);
            add_step(OP_READ, c, 'h08, 0, 0, 1'b0);
        end
        // upper data bits ignored, offset sign-extended on read
        add_step(OP_WRITE, 1, 'h00, 32'h1234_5625, 0, 1'b0);
        add_step(OP_WRITE, 1, 'h04, 32'hABCD_0FFB, 0, 1'b0);
        add_step(OP_WRITE, 4, 'h04, 'h123, 0, 1'b0);
        add_step(OP_WRITE, 6, 'h00, 'h08, 0, 1'b0);
        add_step(OP_READ, 1, 'h00, 0, 'h25, 1'b0);
        add_step(OP_READ, 1, 'h04, 0, -5, 1'b0);
        add_step(OP_READ, 4, 'h04, 0, 'h123, 1'b0);
        add_step(OP_READ, 6, 'h00, 0, 'h08, 1'b0);
        add_step(OP_READ, 0, 'h00, 0, 16, 1'b0);
        add_step(OP_READ, 0, 'h04, 0, 0, 1'b0);
        add_step(OP_READ, 4, 'h00, 0, 16, 1'b0);
        add_step(OP_READ, 5, 'h04, 0, 0, 1'b0);
        // distinct gain and offset per channel, then random samples
        for (int c = 0; c < NUM_CHAN; c++) begin
            add_step(OP_WRITE, c, 'h00, 4 + 2 * c, 0, 1'b0);
            add_step(OP_WRITE, c, 'h04, 100 * c - 350, 0, 1'b0);
        end
        add_step(OP_BURST, 0, 0, 40, 0, 1'b0);
        for (int c = 0; c < NUM_CHAN; c++) begin
            add_step(OP_READ, c, 'h08, 0, 0, 1'b1);
        end
        // large gains force clipping
        add_step(OP_WRITE, 2, 'h00, 'hF0, 0, 1'b0);
        add_step(OP_WRITE, 5, 'h00, 'hF0, 0, 1'b0);
        add_step(OP_BURST, 0, 0, 24, 0, 1'b0);
        add_step(OP_READ, 2, 'h08, 0, 0, 1'b1);
        add_step(OP_READ, 5, 'h08, 0, 0, 1'b1);
        add_step(OP_READ, 0, 'h08, 0, 0, 1'b1);
        // clear by register write, then by agc reset
        add_step(OP_WRITE, 2, 'h08, 0, 0, 1'b0);
        add_step(OP_READ, 2, 'h08, 0, 0, 1'b0);
        add_step(OP_READ, 5, 'h08, 0, 0, 1'b1);
        add_step(OP_CLEAR, 0, 0, 0, 0, 1'b0);
        add_step(OP_READ, 5, 'h08, 0, 0, 1'b0);
        add_step(OP_READ, 0, 'h08, 0, 0, 1'b0);
        // bits outside the mask and unaligned offsets
        add_step(OP_BAD, 3, 'h2000, 'h55, 0, 1'b0);
        add_step(OP_BAD, 3, 'h001, 'h77, 0, 1'b0);
        add_step(OP_BAD, 3, 'h104, 'h321, 0, 1'b0);
        add_step(OP_BAD, 3, 'h200000, 'h11, 0, 1'b0);
        add_step(OP_READ, 3, 'h00, 0, 10, 1'b0);
        add_step(OP_READ, 3, 'h04, 0, -50, 1'b0);
        // unmapped offsets read 0 and ignore writes
        add_step(OP_READ, 2, 'h0C, 0, 0, 1'b0);
        add_step(OP_READ, 2, 'hFC, 0, 0, 1'b0);
        add_step(OP_WRITE, 2, 'h10, -1, 0, 1'b0);
        add_step(OP_WRITE, 2, 'hFC, 'h1234, 0, 1'b0);
        add_step(OP_READ, 2, 'h00, 0, 'hF0, 1'b0);
        add_step(OP_READ, 2, 'h04, 0, -150, 1'b0);
        add_step(OP_READ, 2, 'h08, 0, 0, 1'b0);
    endfunction

    initial begin
        wb_req    = '0;
        agc_reset = 1'b0;
        dat_in    = '0;
        void'($urandom(SEED));
        for (int c = 0; c < NUM_CHAN; c++) begin
            gain_m[c]   = 16;
            offset_m[c] = 0;
            cnt_m[c]    = 0;
        end
        build_table();
        wait_reset();
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule
